/* dma_bus_pkg.sv */
`default_nettype none

package dma_bus_pkg;

    localparam int NUM_STREAMS  = 4;
    localparam int STREAM_IDX_W = 2;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    // address step per transferred word
    localparam int WORD_BYTES = 4;

    // one access on the memory bus
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_cmd_t;

endpackage

`default_nettype wire

/* dma_reg_pkg.sv */
`default_nettype none

package dma_reg_pkg;

    localparam int REG_ADDR_W    = 8;
    localparam int STREAM_STRIDE = 16;

    // offsets inside one stream group
    localparam logic [REG_ADDR_W-1:0] OFS_CR   = 8'h00;
    localparam logic [REG_ADDR_W-1:0] OFS_SAR  = 8'h04;
    localparam logic [REG_ADDR_W-1:0] OFS_DAR  = 8'h08;
    localparam logic [REG_ADDR_W-1:0] OFS_NDTR = 8'h0c;

    // global status and flag clear
    localparam logic [REG_ADDR_W-1:0] ADDR_ISR  = 8'h40;
    localparam logic [REG_ADDR_W-1:0] ADDR_IFCR = 8'h44;

    localparam int NDTR_W = 16;
    localparam int PL_W   = 2;

    typedef struct packed {
        logic [dma_bus_pkg::DATA_W-PL_W-3:0] rsvd;
        logic [PL_W-1:0]                     pl;
        logic                                tcie;
        logic                                en;
    } ctrl_reg_t;

    typedef struct packed {
        logic                           wr;
        logic                           rd;
        logic [REG_ADDR_W-1:0]          addr;
        logic [dma_bus_pkg::DATA_W-1:0] wdata;
    } reg_req_t;

    // what a stream engine needs from the register file
    typedef struct packed {
        logic                           en;
        logic [PL_W-1:0]                pl;
        logic [dma_bus_pkg::ADDR_W-1:0] sar;
        logic [dma_bus_pkg::ADDR_W-1:0] dar;
    } stream_cfg_t;

endpackage

`default_nettype wire

/* dma_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module dma_regs (
    input  logic                                                i_hclk,
    input  logic                                                i_arst_n,
    input  dma_reg_pkg::reg_req_t                               i_reg,
    output logic [dma_bus_pkg::DATA_W-1:0]                      o_reg_rdata,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0]                 i_step,
    output dma_reg_pkg::stream_cfg_t [dma_bus_pkg::NUM_STREAMS-1:0] o_cfg,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                 o_irq
);

    import dma_bus_pkg::*;
    import dma_reg_pkg::*;

    ctrl_reg_t             cr_q   [NUM_STREAMS];
    logic [ADDR_W-1:0]     sar_q  [NUM_STREAMS];
    logic [ADDR_W-1:0]     dar_q  [NUM_STREAMS];
    logic [NDTR_W-1:0]     ndtr_q [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] tcif_q;

    ctrl_reg_t              wctrl;
    logic [NUM_STREAMS-1:0] wr_cr;
    logic [NUM_STREAMS-1:0] wr_sar;
    logic [NUM_STREAMS-1:0] wr_dar;
    logic [NUM_STREAMS-1:0] wr_ndtr;
    logic [NUM_STREAMS-1:0] done;
    logic [NUM_STREAMS-1:0] ifcr_clr;
    logic [NUM_STREAMS-1:0] en_vec;
    logic [NUM_STREAMS-1:0] tcie_vec;
    logic [DATA_W-1:0]      rd_mux;

    function automatic logic hit(
        input logic [REG_ADDR_W-1:0] addr,
        input int                    s,
        input logic [REG_ADDR_W-1:0] ofs
    );
        return addr == REG_ADDR_W'(s * STREAM_STRIDE) + ofs;
    endfunction

    assign wctrl    = ctrl_reg_t'(i_reg.wdata);
    assign ifcr_clr = (i_reg.wr && i_reg.addr == ADDR_IFCR) ?
                      i_reg.wdata[NUM_STREAMS-1:0] : '0;

    // address decode, completion detect and per-stream outputs
    always_comb begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            wr_cr[s]   = i_reg.wr && hit(i_reg.addr, s, OFS_CR);
            // address and count are locked while the stream runs
            wr_sar[s]  = i_reg.wr && !cr_q[s].en && hit(i_reg.addr, s, OFS_SAR);
            wr_dar[s]  = i_reg.wr && !cr_q[s].en && hit(i_reg.addr, s, OFS_DAR);
            wr_ndtr[s] = i_reg.wr && !cr_q[s].en && hit(i_reg.addr, s, OFS_NDTR);
            done[s]    = i_step[s] && (ndtr_q[s] == NDTR_W'(1));
            en_vec[s]   = cr_q[s].en;
            tcie_vec[s] = cr_q[s].tcie;
            o_cfg[s].en  = cr_q[s].en;
            o_cfg[s].pl  = cr_q[s].pl;
            o_cfg[s].sar = sar_q[s];
            o_cfg[s].dar = dar_q[s];
        end
    end

    always_comb begin
        rd_mux = '0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            if (hit(i_reg.addr, s, OFS_CR)) begin
                rd_mux = cr_q[s];
            end
            if (hit(i_reg.addr, s, OFS_SAR)) begin
                rd_mux = sar_q[s];
            end
            if (hit(i_reg.addr, s, OFS_DAR)) begin
                rd_mux = dar_q[s];
            end
            if (hit(i_reg.addr, s, OFS_NDTR)) begin
                rd_mux = DATA_W'(ndtr_q[s]);
            end
        end
        if (i_reg.addr == ADDR_ISR) begin
            rd_mux = DATA_W'(tcif_q);
        end
    end

    always_ff @(posedge i_hclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < NUM_STREAMS; s++) begin
                cr_q[s]   <= '0;
                sar_q[s]  <= '0;
                dar_q[s]  <= '0;
                ndtr_q[s] <= '0;
            end
            tcif_q <= '0;
        end else begin
            for (int s = 0; s < NUM_STREAMS; s++) begin
                if (wr_cr[s]) begin
                    cr_q[s].pl   <= wctrl.pl;
                    cr_q[s].tcie <= wctrl.tcie;
                    // nothing to move with a zero count
                    cr_q[s].en   <= wctrl.en && (ndtr_q[s] != '0);
                end
                if (wr_sar[s]) begin
                    sar_q[s] <= i_reg.wdata;
                end
                if (wr_dar[s]) begin
                    dar_q[s] <= i_reg.wdata;
                end
                if (wr_ndtr[s]) begin
                    ndtr_q[s] <= i_reg.wdata[NDTR_W-1:0];
                end
                if (i_step[s]) begin
                    sar_q[s]  <= sar_q[s] + ADDR_W'(WORD_BYTES);
                    dar_q[s]  <= dar_q[s] + ADDR_W'(WORD_BYTES);
                    ndtr_q[s] <= ndtr_q[s] - 1'b1;
                end
                // last word: stream turns itself off
                if (done[s]) begin
                    cr_q[s].en <= 1'b0;
                end
            end
            tcif_q <= (tcif_q & ~ifcr_clr) | done;
        end
    end

    always_ff @(posedge i_hclk) begin
        if (i_reg.rd) begin
            o_reg_rdata <= rd_mux;
        end
    end

    assign o_irq = tcif_q & tcie_vec;

    // an engine only finishes words for a running stream
    a_step_en: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
        (i_step & ~en_vec) == '0);

endmodule

`default_nettype wire

/* dma_stream.sv */
`default_nettype none
`timescale 1ns/1ps

module dma_stream (
    input  logic                           i_hclk,
    input  logic                           i_arst_n,
    input  dma_reg_pkg::stream_cfg_t       i_cfg,
    input  logic                           i_dreq,
    output logic                           o_req,
    output dma_bus_pkg::bus_cmd_t          o_cmd,
    input  logic                           i_ack,
    input  logic [dma_bus_pkg::DATA_W-1:0] i_rdata,
    output logic                           o_step
);

    import dma_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_REL,
        ST_WR_REQ,
        ST_WR_REL
    } state_t;

    state_t            state_q;
    logic [DATA_W-1:0] data_q;
    logic              wr_phase;

    always_ff @(posedge i_hclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_cfg.en && i_dreq) begin
                        state_q <= ST_RD_REQ;
                    end
                end
                ST_RD_REQ: begin
                    if (i_ack) begin
                        state_q <= ST_RD_REL;
                    end
                end
                // req stays low here for a cycle so others can take the bus
                ST_RD_REL: begin
                    if (!i_ack) begin
                        state_q <= ST_WR_REQ;
                    end
                end
                ST_WR_REQ: begin
                    if (i_ack) begin
                        state_q <= ST_WR_REL;
                    end
                end
                ST_WR_REL: begin
                    if (!i_ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // fetched word, held until the write goes out
    always_ff @(posedge i_hclk) begin
        if (state_q == ST_RD_REQ && i_ack) begin
            data_q <= i_rdata;
        end
    end

    assign wr_phase = (state_q == ST_WR_REQ) || (state_q == ST_WR_REL);

    assign o_req       = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
    assign o_cmd.write = wr_phase;
    assign o_cmd.addr  = wr_phase ? i_cfg.dar : i_cfg.sar;
    assign o_cmd.wdata = wr_phase ? data_q : '0;

    // registers advance on the same edge the engine returns to idle
    assign o_step = (state_q == ST_WR_REL) && !i_ack;

    // relies on the register file freezing sar/dar while a word is in flight
    a_cmd_stable: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
        (o_req && !i_ack) |=> $stable(o_cmd));

endmodule

`default_nettype wire

/* dma_bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module dma_bus_arbiter (
    input  logic                                                i_hclk,
    input  logic                                                i_arst_n,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0]                 i_req,
    input  dma_bus_pkg::bus_cmd_t [dma_bus_pkg::NUM_STREAMS-1:0] i_cmd,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0][dma_reg_pkg::PL_W-1:0] i_pl,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0]                 o_ack,
    output logic [dma_bus_pkg::DATA_W-1:0]                      o_rdata,
    output logic                                                o_bus_req,
    output dma_bus_pkg::bus_cmd_t                               o_bus_cmd,
    input  logic                                                i_bus_ack,
    input  logic [dma_bus_pkg::DATA_W-1:0]                      i_bus_rdata
);

    import dma_bus_pkg::*;
    import dma_reg_pkg::*;

    typedef enum logic [1:0] {
        AR_IDLE,
        AR_REQ,
        AR_ACK,
        AR_DROP
    } arb_state_t;

    arb_state_t              state_q;
    logic [STREAM_IDX_W-1:0] grant_q;
    logic [STREAM_IDX_W-1:0] rr_ptr_q;
    logic [STREAM_IDX_W-1:0] winner;
    logic [STREAM_IDX_W-1:0] idx;
    logic [PL_W-1:0]         best_pl;
    logic                    found;

    // scan from the rr pointer, only a strictly higher level displaces
    always_comb begin
        winner  = rr_ptr_q;
        best_pl = '0;
        found   = 1'b0;
        for (int k = 0; k < NUM_STREAMS; k++) begin
            idx = rr_ptr_q + STREAM_IDX_W'(k);
            if (i_req[idx] && (!found || i_pl[idx] > best_pl)) begin
                winner  = idx;
                best_pl = i_pl[idx];
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge i_hclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q  <= AR_IDLE;
            grant_q  <= '0;
            rr_ptr_q <= '0;
        end else begin
            case (state_q)
                AR_IDLE: begin
                    if (|i_req && !i_bus_ack) begin
                        grant_q  <= winner;
                        rr_ptr_q <= winner + 1'b1;
                        state_q  <= AR_REQ;
                    end
                end
                AR_REQ: begin
                    if (i_bus_ack) begin
                        state_q <= AR_ACK;
                    end
                end
                AR_ACK: begin
                    if (!i_req[grant_q]) begin
                        state_q <= AR_DROP;
                    end
                end
                // hold the stream's ack until memory lets go
                AR_DROP: begin
                    if (!i_bus_ack) begin
                        state_q <= AR_IDLE;
                    end
                end
                default: begin
                    state_q <= AR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_hclk) begin
        if (state_q == AR_REQ && i_bus_ack) begin
            o_rdata <= i_bus_rdata;
        end
    end

    always_comb begin
        o_ack = '0;
        if (state_q == AR_ACK || state_q == AR_DROP) begin
            o_ack[grant_q] = 1'b1;
        end
    end

    assign o_bus_req = (state_q == AR_REQ) || (state_q == AR_ACK);
    assign o_bus_cmd = i_cmd[grant_q];

    // at most one ack, and a fresh ack only goes to a requesting stream
    a_ack_onehot: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
        $onehot0(o_ack) && ((o_ack & ~$past(o_ack) & ~i_req) == '0));

    a_bus_req_rise: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
        $rose(o_bus_req) |-> !i_bus_ack);

endmodule

`default_nettype wire

/* dma_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dma_top (
    input  logic                                i_hclk,
    input  logic                                i_arst_n,
    input  dma_reg_pkg::reg_req_t               i_reg,
    output logic [dma_bus_pkg::DATA_W-1:0]      o_reg_rdata,
    input  logic [dma_bus_pkg::NUM_STREAMS-1:0] i_dreq,
    output logic [dma_bus_pkg::NUM_STREAMS-1:0] o_irq,
    output logic                                o_bus_req,
    output dma_bus_pkg::bus_cmd_t               o_bus_cmd,
    input  logic                                i_bus_ack,
    input  logic [dma_bus_pkg::DATA_W-1:0]      i_bus_rdata
);

    import dma_bus_pkg::*;
    import dma_reg_pkg::*;

    stream_cfg_t [NUM_STREAMS-1:0]            cfg;
    bus_cmd_t [NUM_STREAMS-1:0]               cmd;
    logic [NUM_STREAMS-1:0][PL_W-1:0]         pl;
    logic [NUM_STREAMS-1:0]                   step;
    logic [NUM_STREAMS-1:0]                   req;
    logic [NUM_STREAMS-1:0]                   ack;
    logic [DATA_W-1:0]                        rdata;

    dma_regs dma_regs_inst (
        .i_hclk      (i_hclk),
        .i_arst_n    (i_arst_n),
        .i_reg       (i_reg),
        .o_reg_rdata (o_reg_rdata),
        .i_step      (step),
        .o_cfg       (cfg),
        .o_irq       (o_irq)
    );

    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_stream
        dma_stream dma_stream_inst (
            .i_hclk   (i_hclk),
            .i_arst_n (i_arst_n),
            .i_cfg    (cfg[s]),
            .i_dreq   (i_dreq[s]),
            .o_req    (req[s]),
            .o_cmd    (cmd[s]),
            .i_ack    (ack[s]),
            .i_rdata  (rdata),
            .o_step   (step[s])
        );

        // arbitration levels straight from the control registers
        assign pl[s] = cfg[s].pl;
    end

    dma_bus_arbiter dma_bus_arbiter_inst (
        .i_hclk      (i_hclk),
        .i_arst_n    (i_arst_n),
        .i_req       (req),
        .i_cmd       (cmd),
        .i_pl        (pl),
        .o_ack       (ack),
        .o_rdata     (rdata),
        .o_bus_req   (o_bus_req),
        .o_bus_cmd   (o_bus_cmd),
        .i_bus_ack   (i_bus_ack),
        .i_bus_rdata (i_bus_rdata)
    );

endmodule

`default_nettype wire

/* tb_dma_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_dma_mem (
    input  logic                           i_clk,
    input  logic                           i_arst_n,
    input  logic                           i_req,
    input  dma_bus_pkg::bus_cmd_t          i_cmd,
    output logic                           o_ack,
    output logic [dma_bus_pkg::DATA_W-1:0] o_rdata
);

    import dma_bus_pkg::*;

    localparam int DEPTH = 1024;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [9:0]        idx;
    logic [1:0]        wait_q;
    logic [1:0]        remaining;
    logic              busy_q;
    integer            seed = 32'hacab_8e31;

    // word index, upper address bits wrap
    assign idx = i_cmd.addr[11:2];

    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack   <= 1'b0;
            o_rdata <= '0;
            wait_q  <= '0;
            busy_q  <= 1'b0;
        end else if (o_ack) begin
            // release one cycle after req falls
            if (!i_req) begin
                o_ack <= 1'b0;
            end
        end else if (i_req) begin
            if (busy_q) begin
                remaining = wait_q;
            end else begin
                remaining = 2'($random(seed));
            end
            if (remaining == '0) begin
                o_ack  <= 1'b1;
                busy_q <= 1'b0;
                if (i_cmd.write) begin
                    mem[idx] <= i_cmd.wdata;
                end else begin
                    o_rdata <= mem[idx];
                end
            end else begin
                wait_q <= remaining - 1'b1;
                busy_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_dma.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_dma;

    import dma_bus_pkg::*;
    import dma_reg_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int MAX_COUNT    = 8;
    localparam int PRIO_COUNT   = 2;
    // single stream, four streams, priority pair
    localparam int TOTAL_WORDS  = MAX_COUNT + NUM_STREAMS * MAX_COUNT + 2 * PRIO_COUNT;
    localparam int CYCLE_LIMIT  = TOTAL_WORDS * 2 * 8 + 2000;
    localparam int REGION_BYTES = 256;
    localparam logic [ADDR_W-1:0] SRC_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] DST_BASE = 32'h0000_0800;

    logic                   clk;
    logic                   arst_n;
    reg_req_t               reg_req;
    logic [DATA_W-1:0]      reg_rdata;
    logic [NUM_STREAMS-1:0] dreq;
    logic [NUM_STREAMS-1:0] irq;
    logic                   bus_req;
    bus_cmd_t               bus_cmd;
    logic                   bus_ack;
    logic [DATA_W-1:0]      bus_rdata;

    integer            seed = 32'hacab_8e31;
    int                cycles = 0;
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];

    dma_top dma_top_inst (
        .i_hclk      (clk),
        .i_arst_n    (arst_n),
        .i_reg       (reg_req),
        .o_reg_rdata (reg_rdata),
        .i_dreq      (dreq),
        .o_irq       (irq),
        .o_bus_req   (bus_req),
        .o_bus_cmd   (bus_cmd),
        .i_bus_ack   (bus_ack),
        .i_bus_rdata (bus_rdata)
    );

    tb_dma_mem mem_inst (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_req    (bus_req),
        .i_cmd    (bus_cmd),
        .o_ack    (bus_ack),
        .o_rdata  (bus_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] reg_addr(input int s,
                                                        input logic [REG_ADDR_W-1:0] ofs);
        return REG_ADDR_W'(s * STREAM_STRIDE) + ofs;
    endfunction

    function automatic logic [DATA_W-1:0] ctrl_word(input logic en, input logic tcie,
                                                    input logic [PL_W-1:0] pl);
        ctrl_reg_t c;
        c      = '0;
        c.en   = en;
        c.tcie = tcie;
        c.pl   = pl;
        return c;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        reg_req.wr    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        @(posedge clk);
        #1;
        reg_req.wr = 1'b0;
    endtask

    task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
        reg_req.rd   = 1'b1;
        reg_req.addr = addr;
        @(posedge clk);
        #1;
        reg_req.rd = 1'b0;
        data       = reg_rdata;
    endtask

    task automatic fill_memory();
        logic [DATA_W-1:0] v;
        for (int i = 0; i < MEM_WORDS; i++) begin
            v               = $random(seed) ^ i;
            mem_inst.mem[i] = v;
            ref_mem[i]      = v;
        end
    endtask

    // reference copy in the testbench image
    task automatic copy_words(input logic [31:0] src, input logic [31:0] dst, input int n);
        for (int k = 0; k < n; k++) begin
            ref_mem[dst[11:2] + k] = ref_mem[src[11:2] + k];
        end
    endtask

    task automatic compare_memory(input string name);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_eq(name, ref_mem[i], mem_inst.mem[i]);
        end
    endtask

    task automatic setup_stream(input int s, input logic [31:0] src, input logic [31:0] dst,
                                input int n, input logic tcie, input logic [PL_W-1:0] pl);
        reg_write(reg_addr(s, OFS_SAR), src);
        reg_write(reg_addr(s, OFS_DAR), dst);
        reg_write(reg_addr(s, OFS_NDTR), 32'(n));
        reg_write(reg_addr(s, OFS_CR), ctrl_word(1'b1, tcie, pl));
    endtask

    task automatic wait_isr(input logic [NUM_STREAMS-1:0] mask, input bit toggle);
        logic [DATA_W-1:0] isr;
        isr = '0;
        while ((isr[NUM_STREAMS-1:0] & mask) != mask) begin
            if (toggle) begin
                dreq = NUM_STREAMS'($random(seed));
            end
            reg_read(ADDR_ISR, isr);
        end
    endtask

    initial begin
        logic [31:0]            rd;
        logic [31:0]            sar_w;
        logic [31:0]            dar_w;
        logic [31:0]            ctrl_w;
        logic [31:0]            src;
        logic [31:0]            dst;
        logic [NDTR_W-1:0]      ndtr_w;
        logic [NUM_STREAMS-1:0] mask;
        logic [NUM_STREAMS-1:0] tcie_mask;
        logic [PL_W-1:0]        pl;
        logic [PL_W-1:0]        pa;
        logic [PL_W-1:0]        pb;
        logic                   tcie;
        int                     s3;
        int                     n;
        int                     a;
        int                     b;
        int                     hi;
        int                     cnt [NUM_STREAMS];

        clk     = 1'b0;
        arst_n  = 1'b0;
        reg_req = '0;
        dreq    = '0;
        fill_memory();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // reset values
        for (int s = 0; s < NUM_STREAMS; s++) begin
            for (int r = 0; r < 4; r++) begin
                reg_read(reg_addr(s, REG_ADDR_W'(r * 4)), rd);
                check_eq("reset_regs", 32'h0, rd);
            end
        end
        reg_read(ADDR_ISR, rd);
        check_eq("reset_isr", 32'h0, rd);
        check_eq("reset_irq", 32'h0, 32'(irq));
        check_eq("reset_bus_req", 32'h0, 32'(bus_req));

        // register readback, en stays low with zero count
        for (int s = 0; s < NUM_STREAMS; s++) begin
            sar_w  = $random(seed);
            dar_w  = $random(seed);
            ndtr_w = NDTR_W'($random(seed));
            ctrl_w = $random(seed) & ~32'h1;
            reg_write(reg_addr(s, OFS_SAR), sar_w);
            reg_write(reg_addr(s, OFS_DAR), dar_w);
            reg_write(reg_addr(s, OFS_NDTR), 32'(ndtr_w));
            reg_write(reg_addr(s, OFS_CR), ctrl_w);
            reg_read(reg_addr(s, OFS_SAR), rd);
            check_eq("readback_sar", sar_w, rd);
            reg_read(reg_addr(s, OFS_DAR), rd);
            check_eq("readback_dar", dar_w, rd);
            reg_read(reg_addr(s, OFS_NDTR), rd);
            check_eq("readback_ndtr", 32'(ndtr_w), rd);
            reg_read(reg_addr(s, OFS_CR), rd);
            check_eq("readback_cr", ctrl_w & 32'he, rd);
            reg_write(reg_addr(s, OFS_NDTR), 32'h0);
            reg_write(reg_addr(s, OFS_CR), ctrl_w | 32'h1);
            reg_read(reg_addr(s, OFS_CR), rd);
            check_eq("zero_count_en", ctrl_w & 32'he, rd);
        end

        // one stream, request held high
        s3   = rand_below(NUM_STREAMS);
        n    = 1 + rand_below(MAX_COUNT);
        tcie = 1'($random(seed));
        pl   = PL_W'($random(seed));
        src  = SRC_BASE + s3 * REGION_BYTES;
        dst  = DST_BASE + s3 * REGION_BYTES;
        fill_memory();
        setup_stream(s3, src, dst, n, tcie, pl);
        dreq[s3] = 1'b1;
        wait_isr(NUM_STREAMS'(1 << s3), 1'b0);
        dreq = '0;
        copy_words(src, dst, n);
        compare_memory("single_mem");
        reg_read(reg_addr(s3, OFS_SAR), rd);
        check_eq("single_sar", src + 4 * n, rd);
        reg_read(reg_addr(s3, OFS_DAR), rd);
        check_eq("single_dar", dst + 4 * n, rd);
        reg_read(reg_addr(s3, OFS_NDTR), rd);
        check_eq("single_ndtr", 32'h0, rd);
        reg_read(reg_addr(s3, OFS_CR), rd);
        check_eq("single_cr", ctrl_word(1'b0, tcie, pl), rd);
        reg_read(ADDR_ISR, rd);
        check_eq("single_isr", 32'(1 << s3), rd);
        check_eq("single_irq", tcie ? 32'(1 << s3) : 32'h0, 32'(irq));

        // all streams with toggling requests
        reg_write(ADDR_IFCR, 32'hf);
        fill_memory();
        tcie_mask = '0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            cnt[s]       = 1 + rand_below(MAX_COUNT);
            tcie_mask[s] = 1'($random(seed));
            setup_stream(s, SRC_BASE + s * REGION_BYTES, DST_BASE + s * REGION_BYTES,
                         cnt[s], tcie_mask[s], PL_W'($random(seed)));
        end
        wait_isr('1, 1'b1);
        dreq = '0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            copy_words(SRC_BASE + s * REGION_BYTES, DST_BASE + s * REGION_BYTES, cnt[s]);
        end
        compare_memory("multi_mem");
        reg_read(ADDR_ISR, rd);
        check_eq("multi_isr", 32'hf, rd);
        check_eq("multi_irq", 32'(tcie_mask), 32'(irq));

        // two levels started together
        reg_write(ADDR_IFCR, 32'hf);
        fill_memory();
        a  = rand_below(NUM_STREAMS);
        b  = (a + 1 + rand_below(NUM_STREAMS - 1)) % NUM_STREAMS;
        pa = PL_W'($random(seed));
        pb = pa + PL_W'(1 + rand_below(3));
        setup_stream(a, SRC_BASE + a * REGION_BYTES, DST_BASE + a * REGION_BYTES,
                     PRIO_COUNT, 1'b1, pa);
        setup_stream(b, SRC_BASE + b * REGION_BYTES, DST_BASE + b * REGION_BYTES,
                     PRIO_COUNT, 1'b1, pb);
        mask    = '0;
        mask[a] = 1'b1;
        mask[b] = 1'b1;
        dreq    = mask;
        do begin
            @(posedge clk);
            #1;
        end while (!bus_req);
        hi = (pa > pb) ? a : b;
        check_eq("priority_addr", SRC_BASE + hi * REGION_BYTES, bus_cmd.addr);
        check_eq("priority_write", 32'h0, 32'(bus_cmd.write));
        wait_isr(mask, 1'b0);
        dreq = '0;
        copy_words(SRC_BASE + a * REGION_BYTES, DST_BASE + a * REGION_BYTES, PRIO_COUNT);
        copy_words(SRC_BASE + b * REGION_BYTES, DST_BASE + b * REGION_BYTES, PRIO_COUNT);
        compare_memory("priority_mem");

        // flag clear one bit at a time
        reg_read(ADDR_ISR, rd);
        check_eq("ifcr_before", 32'(mask), rd);
        check_eq("ifcr_irq_before", 32'(mask), 32'(irq));
        reg_write(ADDR_IFCR, 32'(1 << a));
        reg_read(ADDR_ISR, rd);
        check_eq("ifcr_first", 32'(1 << b), rd);
        check_eq("ifcr_irq_first", 32'(1 << b), 32'(irq));
        reg_write(ADDR_IFCR, 32'(1 << b));
        reg_read(ADDR_ISR, rd);
        check_eq("ifcr_second", 32'h0, rd);
        check_eq("ifcr_irq_second", 32'h0, 32'(irq));

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
dma_bus_pkg.sv
dma_reg_pkg.sv
dma_regs.sv
dma_stream.sv
dma_bus_arbiter.sv
dma_top.sv
tb_dma_mem.sv
tb_dma.sv
